/* verilog.f */
hw/trap_pkg.sv
hw/exception_unit.sv
hw/trap_csr_file.sv
hw/trap_controller.sv
hw/trap_top.sv
testbench/trap_asserts.sv
testbench/trap_tb.sv

/* Makefile */
# Verilator build and run of the trap path testbench

TOP    ?= trap_tb
FLIST  ?= verilog.f
VFLAGS ?= --binary --timing --assert
SIM    := obj_dir/V$(TOP)

.PHONY: sim clean

# Fails unless the run prints the pass line
sim:
	verilator $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./$(SIM))"; status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

/* testbench/trap_tb.sv */
// ==========================================================================
// Table-driven testbench for the trap path top level
// Expects MTVEC_RESET of 0x100 and fetch stalls of 0 to 5 cycles
// CSR checks rely on the request port being idle during traps
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module trap_tb;

  localparam int          timeout_cycles = 20;
  localparam logic [31:0] mtvec_val      = 32'h0000_0100;

  // Stimulus row with its expected trap
  typedef struct packed {
    trap_pkg::if_probe_t  ifp;
    trap_pkg::id_probe_t  idp;
    trap_pkg::mem_probe_t memp;
    logic                 exp_exc;
    logic [4:0]           exp_code;
    logic [31:0]          exp_pc;
    logic [31:0]          exp_val;
  } row_t;

  logic                 clk;
  logic                 rst;
  trap_pkg::if_probe_t  if_probe;
  trap_pkg::id_probe_t  id_probe;
  trap_pkg::mem_probe_t mem_probe;
  logic                 mret_req;
  logic                 redirect_valid;
  logic [31:0]          redirect_target;
  logic                 redirect_ready;
  logic                 busy;
  logic                 csr_req_valid;
  trap_pkg::csr_req_t   csr_req;
  logic                 csr_req_ready;
  logic                 csr_rsp_valid;
  trap_pkg::csr_rsp_t   csr_rsp;

  row_t rows[$];
  int   errors;

  trap_top #(
    .MTVEC_RESET (32'h0000_0100)
  ) u_dut (
    .clk             (clk),
    .rst             (rst),
    .if_probe        (if_probe),
    .id_probe        (id_probe),
    .mem_probe       (mem_probe),
    .mret_req        (mret_req),
    .redirect_valid  (redirect_valid),
    .redirect_target (redirect_target),
    .redirect_ready  (redirect_ready),
    .busy            (busy),
    .csr_req_valid   (csr_req_valid),
    .csr_req         (csr_req),
    .csr_req_ready   (csr_req_ready),
    .csr_rsp_valid   (csr_rsp_valid),
    .csr_rsp         (csr_rsp)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ========================================================================
  // Helpers
  // ========================================================================

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  function automatic trap_pkg::if_probe_t ifp(input logic v, input logic [31:0] pc);
    ifp.valid = v;
    ifp.pc    = pc;
  endfunction

  // Arguments follow the field order
  function automatic trap_pkg::id_probe_t idp(input logic v, input logic ill, input logic ec,
                                              input logic eb, input logic [31:0] pc,
                                              input logic [31:0] instr);
    idp.valid       = v;
    idp.illegal     = ill;
    idp.ecall       = ec;
    idp.ebreak      = eb;
    idp.pc          = pc;
    idp.instruction = instr;
  endfunction

  // Arguments follow the field order
  function automatic trap_pkg::mem_probe_t memp(input logic v, input logic rd, input logic wr,
                                                input trap_pkg::mem_width_e w,
                                                input logic [31:0] addr, input logic [31:0] pc);
    memp.valid = v;
    memp.read  = rd;
    memp.write = wr;
    memp.width = w;
    memp.addr  = addr;
    memp.pc    = pc;
  endfunction

  task automatic add_row(input trap_pkg::if_probe_t i, input trap_pkg::id_probe_t d,
                         input trap_pkg::mem_probe_t m, input logic e, input logic [4:0] code,
                         input logic [31:0] pc, input logic [31:0] val);
    row_t r;
    r.ifp      = i;
    r.idp      = d;
    r.memp     = m;
    r.exp_exc  = e;
    r.exp_code = code;
    r.exp_pc   = pc;
    r.exp_val  = val;
    rows.push_back(r);
  endtask

  // One CSR transfer and a compare of the response against the old value
  task automatic csr_expect(input trap_pkg::csr_op_e op, input logic [11:0] addr,
                            input logic [31:0] wdata, input logic [31:0] exp_rdata,
                            input logic exp_err, input string name);
    int cnt;
    cnt = 0;
    @(negedge clk);
    csr_req_valid = 1'b1;
    csr_req.op    = op;
    csr_req.addr  = addr;
    csr_req.wdata = wdata;
    #1;
    while (!csr_req_ready && cnt < timeout_cycles) begin
      @(negedge clk);
      #1;
      cnt++;
    end
    if (!csr_req_ready) begin
      errors++;
      $display("CSR request for %s was never accepted", name);
      csr_req_valid = 1'b0;
    end else begin
      @(negedge clk);
      csr_req_valid = 1'b0;
      cnt = 0;
      while (!csr_rsp_valid && cnt < timeout_cycles) begin
        @(negedge clk);
        cnt++;
      end
      if (!csr_rsp_valid) begin
        errors++;
        $display("No CSR response arrived for %s", name);
      end else begin
        check(name, exp_rdata, csr_rsp.rdata);
        check({name, " err"}, 32'(exp_err), 32'(csr_rsp.err));
      end
    end
  endtask

  task automatic read_csr(input logic [11:0] addr, input logic [31:0] exp, input string name);
    csr_expect(trap_pkg::csr_read, addr, 32'd0, exp, 1'b0, name);
  endtask

  // Waits for the redirect, stalls fetch at random, then completes the handshake
  task automatic take_redirect(input logic [31:0] exp_target, input string name);
    int          cnt;
    int unsigned stalls;
    cnt = 0;
    while (!redirect_valid && cnt < timeout_cycles) begin
      @(negedge clk);
      cnt++;
    end
    if (!redirect_valid) begin
      errors++;
      $display("Redirect for %s never became valid", name);
    end else begin
      check({name, " latency"}, 32'd0, 32'(cnt));
      check(name, exp_target, redirect_target);
      check("busy", 32'd1, 32'(busy));
      stalls = $urandom % 6;
      repeat (stalls) begin
        // Exception while busy must be dropped
        if_probe = ifp(1'b1, 32'hBAD0_0002);
        @(negedge clk);
        check("redirect_valid", 32'd1, 32'(redirect_valid));
        check(name, exp_target, redirect_target);
      end
      if_probe       = '0;
      redirect_ready = 1'b1;
      @(negedge clk);
      redirect_ready = 1'b0;
      check("redirect_valid after transfer", 32'd0, 32'(redirect_valid));
    end
  endtask

  task automatic run_row(input row_t r, input int idx, input logic [31:0] base);
    @(negedge clk);
    if_probe  = r.ifp;
    id_probe  = r.idp;
    mem_probe = r.memp;
    @(negedge clk);
    if_probe  = '0;
    id_probe  = '0;
    mem_probe = '0;
    if (r.exp_exc) begin
      take_redirect(base, $sformatf("row%0d redirect_target", idx));
      // mepc drops the low two pc bits
      read_csr(trap_pkg::mepc, {r.exp_pc[31:2], 2'b00}, $sformatf("row%0d mepc", idx));
      read_csr(trap_pkg::mcause, {27'd0, r.exp_code}, $sformatf("row%0d mcause", idx));
      read_csr(trap_pkg::mtval, r.exp_val, $sformatf("row%0d mtval", idx));
    end else begin
      check($sformatf("row%0d redirect_valid", idx), 32'd0, 32'(redirect_valid));
      check($sformatf("row%0d busy", idx), 32'd0, 32'(busy));
    end
  endtask

  // ========================================================================
  // Stimulus table
  // ========================================================================

  task automatic fill_table();
    // Single causes
    add_row(ifp(1, 32'h2002), '0, '0, 1'b1, 5'd0, 32'h2002, 32'h2002);
    add_row('0, idp(1, 0, 0, 1, 32'h3000, 32'h0010_0073), '0, 1'b1, 5'd3, 32'h3000, 32'h3000);
    add_row('0, idp(1, 0, 1, 0, 32'h3004, 32'h0000_0073), '0, 1'b1, 5'd11, 32'h3004, 32'h0);
    add_row('0, idp(1, 1, 0, 0, 32'h3008, 32'hFFFF_FFFF), '0, 1'b1, 5'd2, 32'h3008,
            32'hFFFF_FFFF);
    add_row('0, '0, memp(1, 1, 0, trap_pkg::width_half, 32'h4001, 32'h5000),
            1'b1, 5'd4, 32'h5000, 32'h4001);
    add_row('0, '0, memp(1, 1, 0, trap_pkg::width_word, 32'h4002, 32'h5004),
            1'b1, 5'd4, 32'h5004, 32'h4002);
    add_row('0, '0, memp(1, 0, 1, trap_pkg::width_word, 32'h4006, 32'h5010),
            1'b1, 5'd6, 32'h5010, 32'h4006);
    add_row('0, '0, memp(1, 1, 0, trap_pkg::width_half_u, 32'h4003, 32'h5014),
            1'b1, 5'd4, 32'h5014, 32'h4003);
    // Bytes, aligned words and invalid stages give no trap
    add_row('0, '0, memp(1, 1, 0, trap_pkg::width_byte, 32'h4003, 32'h5018), 1'b0, 0, 0, 0);
    add_row('0, '0, memp(1, 0, 1, trap_pkg::width_byte_u, 32'h4005, 32'h501C), 1'b0, 0, 0, 0);
    add_row('0, '0, memp(1, 1, 0, trap_pkg::width_word, 32'h4004, 32'h5020), 1'b0, 0, 0, 0);
    add_row(ifp(0, 32'h2006), idp(0, 0, 1, 0, 32'h3010, 32'h0000_0073),
            memp(0, 1, 0, trap_pkg::width_word, 32'h4001, 32'h5030), 1'b0, 0, 0, 0);
    // Several causes at once
    add_row(ifp(1, 32'h2006), idp(1, 0, 0, 1, 32'h3010, 32'h0010_0073), '0,
            1'b1, 5'd0, 32'h2006, 32'h2006);
    add_row('0, idp(1, 1, 1, 1, 32'h3014, 32'h0010_0073), '0, 1'b1, 5'd3, 32'h3014, 32'h3014);
    add_row('0, idp(1, 1, 1, 0, 32'h3018, 32'h0000_0073), '0, 1'b1, 5'd11, 32'h3018, 32'h0);
    add_row('0, idp(1, 1, 0, 0, 32'h301C, 32'hDEAD_BEEF),
            memp(1, 1, 0, trap_pkg::width_word, 32'h4001, 32'h5024),
            1'b1, 5'd2, 32'h301C, 32'hDEAD_BEEF);
    add_row('0, '0, memp(1, 1, 1, trap_pkg::width_word, 32'h4009, 32'h5028),
            1'b1, 5'd4, 32'h5028, 32'h4009);
    // Last row must trap since the CSR section reads its mepc and mcause
    add_row('0, idp(1, 0, 1, 0, 32'h3022, 32'h0000_0073),
            memp(1, 0, 1, trap_pkg::width_half, 32'h400B, 32'h502C),
            1'b1, 5'd11, 32'h3022, 32'h0);
  endtask

  // ========================================================================
  // Main sequence
  // ========================================================================

  initial begin
    row_t last;
    errors = 0;
    void'($urandom(29199));
    rst            = 1'b1;
    if_probe       = '0;
    id_probe       = '0;
    mem_probe      = '0;
    mret_req       = 1'b0;
    redirect_ready = 1'b0;
    csr_req_valid  = 1'b0;
    csr_req        = '0;
    fill_table();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Reset state
    check("redirect_valid", 32'd0, 32'(redirect_valid));
    check("busy", 32'd0, 32'(busy));
    check("csr_rsp_valid", 32'd0, 32'(csr_rsp_valid));
    read_csr(trap_pkg::mtvec, mtvec_val, "reset mtvec");
    read_csr(trap_pkg::mepc, 32'd0, "reset mepc");
    read_csr(trap_pkg::mcause, 32'd0, "reset mcause");
    read_csr(trap_pkg::mtval, 32'd0, "reset mtval");
    read_csr(trap_pkg::mscratch, 32'd0, "reset mscratch");

    foreach (rows[i]) begin
      run_row(rows[i], i, mtvec_val);
    end
    last = rows[rows.size()-1];

    // CSR ops with responses carrying the old value
    csr_expect(trap_pkg::csr_write, trap_pkg::mscratch, 32'h1234_5678, 32'd0, 1'b0, "wr mscratch");
    csr_expect(trap_pkg::csr_set, trap_pkg::mscratch, 32'h0000_00FF, 32'h1234_5678, 1'b0,
               "set mscratch");
    csr_expect(trap_pkg::csr_clear, trap_pkg::mscratch, 32'h0000_0F0F, 32'h1234_56FF, 1'b0,
               "clr mscratch");
    read_csr(trap_pkg::mscratch, 32'h1234_50F0, "mscratch");
    csr_expect(trap_pkg::csr_write, trap_pkg::mtvec, 32'h0000_0203, mtvec_val, 1'b0, "wr mtvec");
    read_csr(trap_pkg::mtvec, 32'h0000_0200, "mtvec");
    csr_expect(trap_pkg::csr_write, trap_pkg::mepc, 32'h0000_1237, {last.exp_pc[31:2], 2'b00},
               1'b0, "wr mepc");
    read_csr(trap_pkg::mepc, 32'h0000_1234, "mepc");
    csr_expect(trap_pkg::csr_write, trap_pkg::mcause, 32'hFFFF_FFFF, {27'd0, last.exp_code},
               1'b0, "wr mcause");
    read_csr(trap_pkg::mcause, 32'h8000_001F, "mcause");
    csr_expect(trap_pkg::csr_write, 12'h7C0, 32'hFFFF_FFFF, 32'd0, 1'b1, "unknown csr");

    // mret goes back to mepc
    @(negedge clk);
    mret_req = 1'b1;
    @(negedge clk);
    mret_req = 1'b0;
    take_redirect(32'h0000_1234, "mret redirect_target");
    read_csr(trap_pkg::mepc, 32'h0000_1234, "mepc after mret");

    // Trap uses the rewritten base
    run_row(rows[0], 0, 32'h0000_0200);

    $display("Summary: %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/trap_asserts.sv */
// ==========================================================================
// Redirect handshake and CSR port properties, bound into both blocks
// Ports a block lacks are tied off so their properties pass vacuously
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module trap_asserts (
  input logic        clk,
  input logic        rst,
  input logic        redirect_valid,
  input logic [31:0] redirect_target,
  input logic        redirect_ready,
  input logic        busy,
  input logic        trap_commit,
  input logic        csr_req_valid,
  input logic        csr_req_ready,
  input logic        csr_rsp_valid
);

  // Target held while fetch stalls
  redirect_stable: assert property (@(posedge clk) disable iff (rst)
    redirect_valid && !redirect_ready |=> redirect_valid && $stable(redirect_target))
    else $error("redirect dropped or changed under back-pressure");

  commit_idle: assert property (@(posedge clk) disable iff (rst) trap_commit |-> !busy)
    else $error("trap committed while busy");

  // Response exactly one cycle after each transfer
  rsp_follows: assert property (@(posedge clk) disable iff (rst)
    csr_req_valid && csr_req_ready |=> csr_rsp_valid)
    else $error("missing CSR response");

  rsp_only_after_req: assert property (@(posedge clk) disable iff (rst)
    !(csr_req_valid && csr_req_ready) |=> !csr_rsp_valid)
    else $error("CSR response without a request");

  reset_quiet: assert property (@(posedge clk) rst |=> !redirect_valid)
    else $error("redirect valid after reset");

endmodule

bind trap_controller trap_asserts u_ctrl_asserts (
  .clk             (clk),
  .rst             (rst),
  .redirect_valid  (redirect_valid),
  .redirect_target (redirect_target),
  .redirect_ready  (redirect_ready),
  .busy            (busy),
  .trap_commit     (trap_commit),
  .csr_req_valid   (1'b0),
  .csr_req_ready   (1'b0),
  .csr_rsp_valid   (1'b0)
);

bind trap_csr_file trap_asserts u_csr_asserts (
  .clk             (clk),
  .rst             (rst),
  .redirect_valid  (1'b0),
  .redirect_target (32'd0),
  .redirect_ready  (1'b1),
  .busy            (1'b0),
  .trap_commit     (trap_commit),
  .csr_req_valid   (csr_req_valid),
  .csr_req_ready   (csr_req_ready),
  .csr_rsp_valid   (csr_rsp_valid)
);

`default_nettype wire

/* hw/trap_top.sv */
// ==========================================================================
// Trap path top: exception unit, trap controller and trap CSR file
// MTVEC_RESET low two bits are dropped by the CSR file
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module trap_top #(
  parameter logic [trap_pkg::xlen-1:0] MTVEC_RESET = 32'h0000_0100
) (
  input  logic                          clk,
  input  logic                          rst,
  // Stage probes
  input  trap_pkg::if_probe_t           if_probe,
  input  trap_pkg::id_probe_t           id_probe,
  input  trap_pkg::mem_probe_t          mem_probe,
  input  logic                          mret_req,
  // Fetch redirect
  output logic                          redirect_valid,
  output logic [trap_pkg::xlen-1:0]     redirect_target,
  input  logic                          redirect_ready,
  output logic                          busy,
  // CSR port
  input  logic                          csr_req_valid,
  input  trap_pkg::csr_req_t            csr_req,
  output logic                          csr_req_ready,
  output logic                          csr_rsp_valid,
  output trap_pkg::csr_rsp_t            csr_rsp
);

  // Exception unit to controller
  logic                      exc;
  trap_pkg::trap_info_t      exc_trap;
  // Controller to CSR file
  logic                      trap_commit;
  trap_pkg::trap_info_t      commit_trap;
  // CSR file back to controller
  logic [trap_pkg::xlen-1:0] mtvec_base;
  logic [trap_pkg::xlen-1:0] mepc;

  exception_unit u_exception_unit (
    .if_probe  (if_probe),
    .id_probe  (id_probe),
    .mem_probe (mem_probe),
    .exc       (exc),
    .trap      (exc_trap)
  );

  trap_controller u_trap_controller (
    .clk             (clk),
    .rst             (rst),
    .exc             (exc),
    .trap_in         (exc_trap),
    .mret_req        (mret_req),
    .mtvec_base      (mtvec_base),
    .mepc            (mepc),
    .trap_commit     (trap_commit),
    .trap_out        (commit_trap),
    .redirect_valid  (redirect_valid),
    .redirect_target (redirect_target),
    .redirect_ready  (redirect_ready),
    .busy            (busy)
  );

  trap_csr_file #(
    .MTVEC_RESET (MTVEC_RESET)
  ) u_trap_csr_file (
    .clk           (clk),
    .rst           (rst),
    .trap_commit   (trap_commit),
    .trap          (commit_trap),
    .csr_req_valid (csr_req_valid),
    .csr_req       (csr_req),
    .csr_req_ready (csr_req_ready),
    .csr_rsp_valid (csr_rsp_valid),
    .csr_rsp       (csr_rsp),
    .mtvec_base    (mtvec_base),
    .mepc          (mepc)
  );

endmodule

`default_nettype wire

/* hw/trap_controller.sv */
// ==========================================================================
// Trap and mret sequencing with a valid/ready fetch redirect
// New exceptions and mret requests are dropped while busy
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module trap_controller (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          exc,
  input  trap_pkg::trap_info_t          trap_in,
  input  logic                          mret_req,
  input  logic [trap_pkg::xlen-1:0]     mtvec_base,
  input  logic [trap_pkg::xlen-1:0]     mepc,
  output logic                          trap_commit,
  output trap_pkg::trap_info_t          trap_out,
  output logic                          redirect_valid,
  output logic [trap_pkg::xlen-1:0]     redirect_target,
  input  logic                          redirect_ready,
  output logic                          busy
);

  // Idle waits for work, redirect holds until fetch takes the target
  typedef enum logic {
    idle     = 1'b0,
    redirect = 1'b1
  } state_e;

  state_e                    state_q;
  state_e                    state_d;
  logic [trap_pkg::xlen-1:0] target_q;

  logic accept_trap;
  logic accept_mret;

  // ========================================================================
  // Request arbitration
  // ========================================================================

  // Exception beats mret in the same cycle
  assign accept_trap = (state_q == idle) && exc;
  assign accept_mret = (state_q == idle) && !exc && mret_req;

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (accept_trap || accept_mret) begin
          state_d = redirect;
        end
      end
      redirect: begin
        // Transfer done on valid and ready
        if (redirect_ready) begin
          state_d = idle;
        end
      end
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Target captured once, held through back-pressure
  always_ff @(posedge clk) begin
    if (accept_trap) begin
      target_q <= mtvec_base;
    end else if (accept_mret) begin
      target_q <= mepc;
    end
  end

  // ========================================================================
  // Outputs
  // ========================================================================

  // CSR file writes on the same edge
  assign trap_commit = accept_trap;
  assign trap_out    = trap_in;

  assign redirect_valid  = (state_q == redirect);
  assign redirect_target = target_q;

  // Pipeline stalls until the redirect is taken
  assign busy = (state_q == redirect);

endmodule

`default_nettype wire

/* hw/trap_csr_file.sv */
// ==========================================================================
// Machine trap CSRs: mtvec, mepc, mcause, mtval, mscratch
// Direct mode mtvec only, low two bits of mtvec and mepc read as zero
// A trap commit blocks the request port for that cycle
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module trap_csr_file #(
  parameter logic [trap_pkg::xlen-1:0] MTVEC_RESET = '0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          trap_commit,
  input  trap_pkg::trap_info_t          trap,
  input  logic                          csr_req_valid,
  input  trap_pkg::csr_req_t            csr_req,
  output logic                          csr_req_ready,
  output logic                          csr_rsp_valid,
  output trap_pkg::csr_rsp_t            csr_rsp,
  output logic [trap_pkg::xlen-1:0]     mtvec_base,
  output logic [trap_pkg::xlen-1:0]     mepc
);

  localparam int xlen = trap_pkg::xlen;

  // Reset base, forced to direct mode alignment
  localparam logic [xlen-1:0] mtvec_init = {MTVEC_RESET[xlen-1:2], 2'b00};
  // Interrupt flag plus exception code field
  localparam logic [xlen-1:0] mcause_mask = 32'h8000_001F;

  logic [xlen-1:0] mtvec_q;
  logic [xlen-1:0] mepc_q;
  logic [xlen-1:0] mcause_q;
  logic [xlen-1:0] mtval_q;
  logic [xlen-1:0] mscratch_q;

  logic            accept;
  logic            hit;
  logic            wr_en;
  logic [xlen-1:0] old_val;
  logic [xlen-1:0] new_val;

  logic               rsp_valid_q;
  trap_pkg::csr_rsp_t rsp_q;

  // ========================================================================
  // Request decode
  // ========================================================================

  // Trap write owns the registers this cycle
  assign csr_req_ready = !trap_commit;
  assign accept        = csr_req_valid && csr_req_ready;

  // Current value, zero on a miss
  always_comb begin
    hit     = 1'b1;
    old_val = '0;
    case (csr_req.addr)
      trap_pkg::mtvec:    old_val = mtvec_q;
      trap_pkg::mscratch: old_val = mscratch_q;
      trap_pkg::mepc:     old_val = mepc_q;
      trap_pkg::mcause:   old_val = mcause_q;
      trap_pkg::mtval:    old_val = mtval_q;
      default:            hit     = 1'b0;
    endcase
  end

  // Read-modify-write result
  always_comb begin
    case (csr_req.op)
      trap_pkg::csr_write: new_val = csr_req.wdata;
      trap_pkg::csr_set:   new_val = old_val | csr_req.wdata;
      trap_pkg::csr_clear: new_val = old_val & ~csr_req.wdata;
      default:             new_val = old_val;
    endcase
  end

  // Reads and unknown addresses leave state alone
  assign wr_en = accept && hit && (csr_req.op != trap_pkg::csr_read);

  // ========================================================================
  // Register update
  // ========================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      mtvec_q    <= mtvec_init;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mscratch_q <= '0;
    end else if (trap_commit) begin
      mepc_q   <= {trap.pc[xlen-1:2], 2'b00};
      mcause_q <= {{(xlen-5){1'b0}}, trap.code};
      mtval_q  <= trap.val;
    end else if (wr_en) begin
      case (csr_req.addr)
        trap_pkg::mtvec:    mtvec_q    <= {new_val[xlen-1:2], 2'b00};
        trap_pkg::mscratch: mscratch_q <= new_val;
        trap_pkg::mepc:     mepc_q     <= {new_val[xlen-1:2], 2'b00};
        trap_pkg::mcause:   mcause_q   <= new_val & mcause_mask;
        trap_pkg::mtval:    mtval_q    <= new_val;
        default:            ;
      endcase
    end
  end

  // Response one cycle after the transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= accept;
    end
  end

  // Old value for every op
  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_q.rdata <= old_val;
      rsp_q.err   <= !hit;
    end
  end

  assign csr_rsp_valid = rsp_valid_q;
  assign csr_rsp       = rsp_q;

  // Redirect sources for the controller
  assign mtvec_base = mtvec_q;
  assign mepc       = mepc_q;

endmodule

`default_nettype wire

/* hw/exception_unit.sv */
// ==========================================================================
// Picks the highest-priority synchronous exception from IF, ID and MEM
// Purely combinational, stage probes must be stable within the cycle
// ecall always reports the M-mode cause
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module exception_unit (
  input  trap_pkg::if_probe_t  if_probe,
  input  trap_pkg::id_probe_t  id_probe,
  input  trap_pkg::mem_probe_t mem_probe,
  output logic                 exc,
  output trap_pkg::trap_info_t trap
);

  // ========================================================================
  // Per-stage detection
  // ========================================================================

  // Fetch pc must be word aligned
  logic if_misaligned;
  // ID stage causes
  logic id_ebreak_exc;
  logic id_ecall_exc;
  logic id_illegal_exc;
  // MEM stage causes
  logic mem_addr_bad;
  logic mem_load_misaligned;
  logic mem_store_misaligned;

  assign if_misaligned  = if_probe.valid && (if_probe.pc[1:0] != 2'b00);

  assign id_ebreak_exc  = id_probe.valid && id_probe.ebreak;
  assign id_ecall_exc   = id_probe.valid && id_probe.ecall;
  assign id_illegal_exc = id_probe.valid && id_probe.illegal;

  // Alignment check by access size
  always_comb begin
    mem_addr_bad = 1'b0;
    case (mem_probe.width)
      trap_pkg::width_half,
      trap_pkg::width_half_u: mem_addr_bad = mem_probe.addr[0];
      trap_pkg::width_word:   mem_addr_bad = (mem_probe.addr[1:0] != 2'b00);
      // Bytes never fault
      trap_pkg::width_byte,
      trap_pkg::width_byte_u: mem_addr_bad = 1'b0;
      default:                mem_addr_bad = 1'b0;
    endcase
  end

  assign mem_load_misaligned  = mem_probe.valid && mem_probe.read && mem_addr_bad;
  assign mem_store_misaligned = mem_probe.valid && mem_probe.write && mem_addr_bad;

  // ========================================================================
  // Priority encoder
  // ========================================================================
  // Order: fetch misaligned, ebreak, ecall, illegal, load, store

  always_comb begin
    exc  = 1'b0;
    trap = '0;

    if (if_misaligned) begin
      exc       = 1'b1;
      trap.code = trap_pkg::inst_addr_misaligned;
      trap.pc   = if_probe.pc;
      trap.val  = if_probe.pc;
    end else if (id_ebreak_exc) begin
      exc       = 1'b1;
      trap.code = trap_pkg::breakpoint;
      trap.pc   = id_probe.pc;
      trap.val  = id_probe.pc;
    end else if (id_ecall_exc) begin
      // No tval for environment calls
      exc       = 1'b1;
      trap.code = trap_pkg::ecall_m;
      trap.pc   = id_probe.pc;
      trap.val  = '0;
    end else if (id_illegal_exc) begin
      // Faulting encoding goes to mtval
      exc       = 1'b1;
      trap.code = trap_pkg::illegal_inst;
      trap.pc   = id_probe.pc;
      trap.val  = id_probe.instruction;
    end else if (mem_load_misaligned) begin
      exc       = 1'b1;
      trap.code = trap_pkg::load_addr_misaligned;
      trap.pc   = mem_probe.pc;
      trap.val  = mem_probe.addr;
    end else if (mem_store_misaligned) begin
      exc       = 1'b1;
      trap.code = trap_pkg::store_addr_misaligned;
      trap.pc   = mem_probe.pc;
      trap.val  = mem_probe.addr;
    end
  end

endmodule

`default_nettype wire

/* hw/trap_pkg.sv */
// ==========================================================================
// Shared widths, encodings and bundles for the machine-mode trap path
// RV32 only, no interrupt causes and no privilege modes below M
// ==========================================================================
`default_nettype none

package trap_pkg;

  // Data and address width
  localparam int xlen = 32;

  // Synchronous exception codes, as written to mcause
  typedef enum logic [4:0] {
    inst_addr_misaligned  = 5'd0,
    illegal_inst          = 5'd2,
    breakpoint            = 5'd3,
    load_addr_misaligned  = 5'd4,
    store_addr_misaligned = 5'd6,
    ecall_m               = 5'd11
  } cause_e;

  // Load/store funct3 encodings
  typedef enum logic [2:0] {
    width_byte   = 3'b000,
    width_half   = 3'b001,
    width_word   = 3'b010,
    width_byte_u = 3'b100,
    width_half_u = 3'b101
  } mem_width_e;

  // CSR access kinds
  typedef enum logic [1:0] {
    csr_read  = 2'd0,
    csr_write = 2'd1,
    csr_set   = 2'd2,
    csr_clear = 2'd3
  } csr_op_e;

  // Implemented CSR addresses
  typedef enum logic [11:0] {
    mtvec    = 12'h305,
    mscratch = 12'h340,
    mepc     = 12'h341,
    mcause   = 12'h342,
    mtval    = 12'h343
  } csr_addr_e;

  // ========================================================================
  // Stage probes and trap bundles
  // ========================================================================

  // IF stage probe
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
  } if_probe_t;

  // ID stage probe
  typedef struct packed {
    logic            valid;
    logic            illegal;
    logic            ecall;
    logic            ebreak;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instruction;
  } id_probe_t;

  // MEM stage probe
  typedef struct packed {
    logic            valid;
    logic            read;
    logic            write;
    mem_width_e      width;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] pc;
  } mem_probe_t;

  // Selected exception
  typedef struct packed {
    cause_e          code;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] val;
  } trap_info_t;

  // Address is raw so unknown CSRs can be requested
  typedef struct packed {
    csr_op_e         op;
    logic [11:0]     addr;
    logic [xlen-1:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic [xlen-1:0] rdata;
    logic            err;
  } csr_rsp_t;

endpackage

`default_nettype wire
